// ==== build.f ====
source/panel_geometry_pkg.sv
source/panel_cmd_pkg.sv
source/cmd_dispatch.sv
source/cmd_fillrect.sv
source/fill_area_walker.sv
source/frame_buffer.sv
source/panel_cmd_top.sv
test/panel_cmd_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the panel command processor testbench with Verilator, run it and judge the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module panel_cmd_tb -f build.f \
    || { echo "Verilator build failed"; exit 1; }
output=$(./obj_dir/Vpanel_cmd_tb)
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -qx "Done: no errors" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== test/panel_cmd_tb.sv ====
/* Testbench for the LED panel command processor: random rectangle fills
   checked against a frame-buffer model through the read port */
`timescale 1ns/10ps
`default_nettype none

module panel_cmd_tb;

    localparam int num_fills = 34;
    localparam int spot_reads = 4;
    localparam int command_cycles = 10 * 4 + 4096 + 8;
    localparam int timeout_cycles = 40 * command_cycles + 2 * 2048 * 2
        + num_fills * spot_reads * 2 + 1000;

    logic clk;
    logic reset;
    logic [7:0] cmd_data;
    logic cmd_valid;
    logic [panel_geometry_pkg::row_bits-1:0] rd_row;
    logic [panel_geometry_pkg::column_bits-1:0] rd_column;
    wire cmd_ready;
    wire cmd_done;
    wire cmd_error;
    wire [panel_geometry_pkg::color_bits-1:0] rd_data;

    logic [15:0] model [panel_geometry_pkg::pixel_height][panel_geometry_pkg::pixel_width];
    logic [31:0] lcg_state = 32'd79212;
    int mismatch_count;
    int failure_count;
    int cycle_count;

    panel_cmd_top i_dut (
        .clk       (clk),
        .reset     (reset),
        .cmd_data  (cmd_data),
        .cmd_valid (cmd_valid),
        .rd_row    (rd_row),
        .rd_column (rd_column),
        .cmd_ready (cmd_ready),
        .cmd_done  (cmd_done),
        .cmd_error (cmd_error),
        .rd_data   (rd_data)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;
    endfunction

    function automatic int random_gap();
        return int'(next_random() % 4);
    endfunction

    function automatic panel_cmd_pkg::fill_area_t random_area();
        panel_cmd_pkg::fill_area_t area;
        area.x1 = 7'(next_random() % 72);
        area.y1 = 6'(next_random() % 36);
        area.width = 7'(next_random() % 40);
        area.height = 6'(next_random() % 20);
        area.color = 16'(next_random());
        return area;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail: %s is 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
            mismatch_count++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("Error: %s at %0t", what, $time);
        failure_count++;
    endtask

    task automatic expect_idle();
        if (!cmd_ready) begin
            report_failure("cmd_ready low with no command in progress");
        end
        check_value("cmd_done", cmd_done, 0);
    endtask

    // Offer one byte after an idle gap and hold it until the DUT takes it
    task automatic send_byte(input logic [7:0] value, input int gap);
        int waited;
        waited = 0;
        cmd_valid = 1'b0;
        repeat (gap) next_cycle();
        cmd_data = value;
        cmd_valid = 1'b1;
        while (!cmd_ready && waited < command_cycles) begin
            next_cycle();
            waited++;
        end
        if (!cmd_ready) begin
            report_failure("a byte was offered but cmd_ready never rose");
        end
        next_cycle();
        cmd_valid = 1'b0;
    endtask

    task automatic send_fill(input panel_cmd_pkg::fill_area_t area, input bit use_gaps);
        send_byte(panel_cmd_pkg::op_fillrect, use_gaps ? random_gap() : 0);
        send_byte(8'(area.x1), use_gaps ? random_gap() : 0);
        send_byte(8'(area.y1), use_gaps ? random_gap() : 0);
        send_byte(8'(area.width), use_gaps ? random_gap() : 0);
        send_byte(8'(area.height), use_gaps ? random_gap() : 0);
        send_byte(area.color[15:8], use_gaps ? random_gap() : 0);
        send_byte(area.color[7:0], use_gaps ? random_gap() : 0);
    endtask

    // Off-panel parts of the rectangle leave the model alone
    task automatic apply_fill(input panel_cmd_pkg::fill_area_t area);
        for (int r = int'(area.y1); r < int'(area.y1) + int'(area.height); r++) begin
            for (int c = int'(area.x1); c < int'(area.x1) + int'(area.width); c++) begin
                if (r < panel_geometry_pkg::pixel_height && c < panel_geometry_pkg::pixel_width) begin
                    model[r][c] = area.color;
                end
            end
        end
    endtask

    // The stream stays closed until the single completion pulse
    task automatic wait_for_done();
        int waited;
        waited = 0;
        while (!cmd_done && waited < command_cycles) begin
            check_value("cmd_ready", cmd_ready, 0);
            next_cycle();
            waited++;
        end
        if (!cmd_done) begin
            report_failure("cmd_done did not arrive");
        end else begin
            check_value("cmd_ready", cmd_ready, 0);
            next_cycle();
            check_value("cmd_done", cmd_done, 0);
            check_value("cmd_ready", cmd_ready, 1);
        end
    endtask

    task automatic check_pixel(input int row, input int column);
        rd_row = 5'(row);
        rd_column = 6'(column);
        next_cycle();
        check_value($sformatf("rd_data[%0d][%0d]", row, column), rd_data, model[row][column]);
    endtask

    task automatic full_readback();
        for (int r = 0; r < panel_geometry_pkg::pixel_height; r++) begin
            for (int c = 0; c < panel_geometry_pkg::pixel_width; c++) begin
                check_pixel(r, c);
            end
        end
    endtask

    task automatic run_fill(input panel_cmd_pkg::fill_area_t area, input bit use_gaps);
        expect_idle();
        send_fill(area, use_gaps);
        apply_fill(area);
        wait_for_done();
        check_pixel(int'(area.y1) % 32, int'(area.x1) % 64);
        repeat (spot_reads) check_pixel(int'(next_random() % 32), int'(next_random() % 64));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Clock, watchdog and test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Error: the run did not finish within %0d cycles", timeout_cycles);
        $display("Value mismatches: %0d, other failures: %0d", mismatch_count, failure_count + 1);
        $display("Done: errors found");
        $finish;
    end

    initial begin : stimulus
        panel_cmd_pkg::fill_area_t area;
        int waited;
        reset = 1'b1;
        cmd_data = '0;
        cmd_valid = 1'b0;
        rd_row = '0;
        rd_column = '0;
        mismatch_count = 0;
        failure_count = 0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        next_cycle();
        check_value("cmd_ready", cmd_ready, 1);
        check_value("cmd_done", cmd_done, 0);
        check_value("cmd_error", cmd_error, 0);

        // The frame buffer has no reset, so the panel is cleared first
        send_byte(panel_cmd_pkg::op_clear, 0);
        for (int r = 0; r < panel_geometry_pkg::pixel_height; r++) begin
            for (int c = 0; c < panel_geometry_pkg::pixel_width; c++) begin
                model[r][c] = '0;
            end
        end
        wait_for_done();
        full_readback();

        send_byte(panel_cmd_pkg::op_nop, 0);
        repeat (4) begin
            expect_idle();
            next_cycle();
        end

        for (int i = 0; i < num_fills; i++) begin
            area = random_area();
            // Fixed cases past the right and bottom edges, with no size, fully off panel
            case (i)
                1: begin
                    area.x1 = 7'd50;
                    area.width = 7'd30;
                end
                2: begin
                    area.y1 = 6'd25;
                    area.height = 6'd15;
                end
                3: area.width = '0;
                4: area.height = '0;
                5: area.x1 = 7'd70;
                default: begin
                end
            endcase
            run_fill(area, 1'b1);

            if (i == num_fills / 2) begin
                // Bytes offered during a walk must wait for the stream to reopen
                area = random_area();
                expect_idle();
                send_fill(area, 1'b0);
                apply_fill(area);
                cmd_data = 8'hee;
                cmd_valid = 1'b1;
                waited = 0;
                while (!cmd_done && waited < command_cycles) begin
                    check_value("cmd_ready", cmd_ready, 0);
                    next_cycle();
                    waited++;
                end
                cmd_valid = 1'b0;
                if (!cmd_done) begin
                    report_failure("cmd_done did not arrive");
                end
                next_cycle();
                check_value("cmd_error", cmd_error, 0);
                run_fill(random_area(), 1'b0);

                send_byte(8'h5a, random_gap());
                check_value("cmd_error", cmd_error, 1);
                expect_idle();
            end
        end

        full_readback();
        check_value("cmd_error", cmd_error, 1);
        $display("Value mismatches: %0d, other failures: %0d", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/panel_cmd_top.sv ====
/* LED panel command processor: byte-stream command decode, rectangle fill
   and the frame buffer with its read port */
`timescale 1ns/10ps
`default_nettype none

module panel_cmd_top (
    input  wire                                       clk,
    input  wire                                       reset,
    input  wire [7:0]                                 cmd_data,
    input  wire                                       cmd_valid,
    input  wire [panel_geometry_pkg::row_bits-1:0]    rd_row,
    input  wire [panel_geometry_pkg::column_bits-1:0] rd_column,
    output wire                                       cmd_ready,
    output wire                                       cmd_done,
    output wire                                       cmd_error,
    output wire [panel_geometry_pkg::color_bits-1:0]  rd_data
);

    panel_cmd_pkg::cmd_byte_t cmd_arg;
    panel_cmd_pkg::fill_area_t area_request;
    panel_cmd_pkg::fill_area_t walk_area;
    panel_cmd_pkg::ram_write_t ram_write;
    logic arg_ready;
    logic area_valid;
    logic walk_start;
    logic walk_done;

    cmd_dispatch i_dispatch (
        .clk          (clk),
        .reset        (reset),
        .cmd_data     (cmd_data),
        .cmd_valid    (cmd_valid),
        .arg_ready    (arg_ready),
        .area_request (area_request),
        .area_valid   (area_valid),
        .walk_done    (walk_done),
        .cmd_ready    (cmd_ready),
        .cmd_arg      (cmd_arg),
        .walk_start   (walk_start),
        .walk_area    (walk_area),
        .cmd_done     (cmd_done),
        .cmd_error    (cmd_error)
    );

    cmd_fillrect i_fillrect (
        .clk          (clk),
        .reset        (reset),
        .cmd_arg      (cmd_arg),
        .arg_ready    (arg_ready),
        .area_request (area_request),
        .area_valid   (area_valid)
    );

    fill_area_walker i_walker (
        .clk        (clk),
        .reset      (reset),
        .walk_start (walk_start),
        .walk_area  (walk_area),
        .ram_write  (ram_write),
        .walk_done  (walk_done)
    );

    frame_buffer i_frame_buffer (
        .clk       (clk),
        .ram_write (ram_write),
        .rd_row    (rd_row),
        .rd_column (rd_column),
        .rd_data   (rd_data)
    );

endmodule

`default_nettype wire

// ==== source/frame_buffer.sv ====
/* Panel frame buffer: one 16-bit word per pixel, byte-lane writes and a
   registered read port for the scan-out side */
`timescale 1ns/10ps
`default_nettype none

module frame_buffer (
    input  wire                                         clk,
    input  wire panel_cmd_pkg::ram_write_t              ram_write,
    input  wire [panel_geometry_pkg::row_bits-1:0]      rd_row,
    input  wire [panel_geometry_pkg::column_bits-1:0]   rd_column,
    output logic [panel_geometry_pkg::color_bits-1:0]   rd_data
);

    logic [panel_geometry_pkg::color_bits-1:0] pixels
        [panel_geometry_pkg::pixel_width * panel_geometry_pkg::pixel_height];

    // Row-major addressing, the row forms the upper address bits
    always_ff @(posedge clk) begin
        if (ram_write.write_enable) begin
            pixels[{ram_write.row, ram_write.column}][ram_write.pixel * 8 +: 8] <=
                ram_write.data;
        end
        rd_data <= pixels[{rd_row, rd_column}];
    end

    a_write_address_known: assert property (
        @(posedge clk)
        ram_write.write_enable |-> !$isunknown({ram_write.row, ram_write.column, ram_write.pixel})
    );

endmodule

`default_nettype wire

// ==== source/fill_area_walker.sv ====
/* Area walker: steps through the visible part of a rectangle and writes one
   color byte per cycle into the frame buffer */
`timescale 1ns/10ps
`default_nettype none

module fill_area_walker (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       walk_start,
    input  wire panel_cmd_pkg::fill_area_t walk_area,
    output panel_cmd_pkg::ram_write_t ram_write,
    output logic                      walk_done
);

    logic [panel_geometry_pkg::column_bits+1:0] column_sum;
    logic [panel_geometry_pkg::row_bits+1:0] row_sum;
    logic [panel_geometry_pkg::column_bits:0] column_limit;
    logic [panel_geometry_pkg::row_bits:0] row_limit;
    logic area_empty;

    logic busy;
    logic [panel_geometry_pkg::column_bits:0] column_count;
    logic [panel_geometry_pkg::column_bits:0] column_start;
    logic [panel_geometry_pkg::column_bits:0] column_end;
    logic [panel_geometry_pkg::row_bits:0] row_count;
    logic [panel_geometry_pkg::row_bits:0] row_end;
    logic [panel_geometry_pkg::pixel_select_bits-1:0] pixel_count;
    logic [panel_geometry_pkg::color_bits-1:0] color;
    logic last_pixel;
    logic last_column;
    logic last_row;

    // Clip the far corner to the panel so off-panel parts cost no cycles
    always_comb begin
        column_sum = {1'b0, walk_area.x1} + {1'b0, walk_area.width};
        row_sum = {1'b0, walk_area.y1} + {1'b0, walk_area.height};
        if (column_sum > panel_geometry_pkg::pixel_width) begin
            column_limit = (panel_geometry_pkg::column_bits + 1)'(panel_geometry_pkg::pixel_width);
        end else begin
            column_limit = column_sum[panel_geometry_pkg::column_bits:0];
        end
        if (row_sum > panel_geometry_pkg::pixel_height) begin
            row_limit = (panel_geometry_pkg::row_bits + 1)'(panel_geometry_pkg::pixel_height);
        end else begin
            row_limit = row_sum[panel_geometry_pkg::row_bits:0];
        end
        area_empty = (walk_area.x1 >= column_limit) || (walk_area.y1 >= row_limit);
    end

    assign last_pixel = pixel_count ==
        (panel_geometry_pkg::pixel_select_bits)'(panel_geometry_pkg::bytes_per_pixel - 1);
    assign last_column = column_count + 1'b1 == column_end;
    assign last_row = row_count + 1'b1 == row_end;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            walk_done <= 1'b0;
            column_count <= '0;
            row_count <= '0;
            pixel_count <= '0;
        end else begin
            walk_done <= 1'b0;
            if (walk_start) begin
                busy <= !area_empty;
                walk_done <= area_empty;
                column_count <= walk_area.x1;
                row_count <= walk_area.y1;
                pixel_count <= '0;
            end else if (busy) begin
                // Pixel bytes step fastest, then columns, then rows
                if (!last_pixel) begin
                    pixel_count <= pixel_count + 1'b1;
                end else begin
                    pixel_count <= '0;
                    if (!last_column) begin
                        column_count <= column_count + 1'b1;
                    end else begin
                        column_count <= column_start;
                        row_count <= row_count + 1'b1;
                        if (last_row) begin
                            busy <= 1'b0;
                            walk_done <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (walk_start) begin
            column_start <= walk_area.x1;
            column_end <= column_limit;
            row_end <= row_limit;
            color <= walk_area.color;
        end
    end

    always_comb begin
        ram_write.row = row_count[panel_geometry_pkg::row_bits-1:0];
        ram_write.column = column_count[panel_geometry_pkg::column_bits-1:0];
        ram_write.pixel = pixel_count;
        ram_write.data = color[pixel_count * 8 +: 8];
        ram_write.write_enable = busy;
    end

    // Clipping must keep every write inside the panel
    a_write_in_panel: assert property (
        @(posedge clk) disable iff (reset)
        ram_write.write_enable |-> (row_count < panel_geometry_pkg::pixel_height) &&
                                   (column_count < panel_geometry_pkg::pixel_width)
    );

endmodule

`default_nettype wire

// ==== source/cmd_fillrect.sv ====
/* Fill-rectangle argument capture: collects origin, size and color bytes
   and presents them as one area request */
`timescale 1ns/10ps
`default_nettype none

module cmd_fillrect (
    input  wire                       clk,
    input  wire                       reset,
    input  wire panel_cmd_pkg::cmd_byte_t cmd_arg,
    output logic                      arg_ready,
    output panel_cmd_pkg::fill_area_t area_request,
    output logic                      area_valid
);

    typedef enum logic [2:0] {
        st_x1,
        st_y1,
        st_width,
        st_height,
        st_color,
        st_present
    } capture_state_e;

    capture_state_e state;
    panel_cmd_pkg::fill_area_t area;
    logic [panel_geometry_pkg::column_byte_count_bits-1:0] column_byte_count;
    logic [panel_geometry_pkg::pixel_select_bits-1:0] color_byte_count;

    assign area_request = area;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_x1;
            arg_ready <= 1'b1;
            area_valid <= 1'b0;
            area <= '0;
            column_byte_count <= (panel_geometry_pkg::column_byte_count_bits)'(
                panel_geometry_pkg::column_arg_bytes - 1);
            color_byte_count <= (panel_geometry_pkg::pixel_select_bits)'(
                panel_geometry_pkg::bytes_per_pixel - 1);
        end else begin
            area_valid <= 1'b0;
            case (state)
                // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
                // Column fields arrive most significant byte first
                // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
                st_x1: begin
                    if (cmd_arg.valid) begin
                        area.x1 <= (panel_geometry_pkg::column_bits + 1)'(
                            {area.x1, cmd_arg.data});
                        if (column_byte_count == '0) begin
                            column_byte_count <= (panel_geometry_pkg::column_byte_count_bits)'(
                                panel_geometry_pkg::column_arg_bytes - 1);
                            state <= st_y1;
                        end else begin
                            column_byte_count <= column_byte_count - 1'b1;
                        end
                    end
                end
                st_y1: begin
                    if (cmd_arg.valid) begin
                        area.y1 <= cmd_arg.data[panel_geometry_pkg::row_bits:0];
                        state <= st_width;
                    end
                end
                st_width: begin
                    if (cmd_arg.valid) begin
                        area.width <= (panel_geometry_pkg::column_bits + 1)'(
                            {area.width, cmd_arg.data});
                        if (column_byte_count == '0) begin
                            state <= st_height;
                        end else begin
                            column_byte_count <= column_byte_count - 1'b1;
                        end
                    end
                end
                st_height: begin
                    if (cmd_arg.valid) begin
                        area.height <= cmd_arg.data[panel_geometry_pkg::row_bits:0];
                        state <= st_color;
                    end
                end
                st_color: begin
                    if (cmd_arg.valid) begin
                        area.color <= (panel_geometry_pkg::color_bits)'(
                            {area.color, cmd_arg.data});
                        if (color_byte_count == '0) begin
                            arg_ready <= 1'b0;
                            area_valid <= 1'b1;
                            state <= st_present;
                        end else begin
                            color_byte_count <= color_byte_count - 1'b1;
                        end
                    end
                end
                // The request is read this cycle, then everything is rearmed
                default: begin
                    arg_ready <= 1'b1;
                    area <= '0;
                    column_byte_count <= (panel_geometry_pkg::column_byte_count_bits)'(
                        panel_geometry_pkg::column_arg_bytes - 1);
                    color_byte_count <= (panel_geometry_pkg::pixel_select_bits)'(
                        panel_geometry_pkg::bytes_per_pixel - 1);
                    state <= st_x1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/cmd_dispatch.sv ====
/* Command dispatcher: decodes opcodes, routes fill-rectangle arguments to the
   capture block, starts the area walker and reports completion */
`timescale 1ns/10ps
`default_nettype none

module cmd_dispatch (
    input  wire                       clk,
    input  wire                       reset,
    input  wire [7:0]                 cmd_data,
    input  wire                       cmd_valid,
    input  wire                       arg_ready,
    input  wire panel_cmd_pkg::fill_area_t area_request,
    input  wire                       area_valid,
    input  wire                       walk_done,
    output logic                      cmd_ready,
    output panel_cmd_pkg::cmd_byte_t  cmd_arg,
    output logic                      walk_start,
    output panel_cmd_pkg::fill_area_t walk_area,
    output logic                      cmd_done,
    output logic                      cmd_error
);

    typedef enum logic [1:0] {
        st_opcode,
        st_fillrect_args,
        st_walking,
        st_finish
    } dispatch_state_e;

    dispatch_state_e state;
    panel_cmd_pkg::cmd_opcode_e opcode;
    logic take;

    assign opcode = panel_cmd_pkg::cmd_opcode_e'(cmd_data);
    assign take = cmd_valid && cmd_ready;

    // While arguments flow the capture block decides when a byte is taken
    always_comb begin
        case (state)
            st_opcode:        cmd_ready = 1'b1;
            st_fillrect_args: cmd_ready = arg_ready;
            default:          cmd_ready = 1'b0;
        endcase
    end

    assign cmd_arg.data = cmd_data;
    assign cmd_arg.valid = take && (state == st_fillrect_args);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_opcode;
            walk_start <= 1'b0;
            cmd_done <= 1'b0;
            cmd_error <= 1'b0;
        end else begin
            walk_start <= 1'b0;
            cmd_done <= 1'b0;
            case (state)
                st_opcode: begin
                    if (take) begin
                        case (opcode)
                            panel_cmd_pkg::op_nop: begin
                            end
                            panel_cmd_pkg::op_fillrect: state <= st_fillrect_args;
                            panel_cmd_pkg::op_clear: begin
                                walk_start <= 1'b1;
                                state <= st_walking;
                            end
                            // Unknown opcodes cost one byte and latch the error flag
                            default: cmd_error <= 1'b1;
                        endcase
                    end
                end
                st_fillrect_args: begin
                    if (area_valid) begin
                        walk_start <= 1'b1;
                        state <= st_walking;
                    end
                end
                st_walking: begin
                    if (walk_done) begin
                        cmd_done <= 1'b1;
                        state <= st_finish;
                    end
                end
                default: state <= st_opcode;
            endcase
        end
    end

    // Area handed to the walker, either the captured rectangle or the whole panel
    always_ff @(posedge clk) begin
        if (state == st_opcode && take && opcode == panel_cmd_pkg::op_clear) begin
            walk_area <= '{
                x1:     '0,
                y1:     '0,
                width:  (panel_geometry_pkg::column_bits + 1)'(panel_geometry_pkg::pixel_width),
                height: (panel_geometry_pkg::row_bits + 1)'(panel_geometry_pkg::pixel_height),
                color:  '0
            };
        end else if (state == st_fillrect_args && area_valid) begin
            walk_area <= area_request;
        end
    end

    // The host must never see a free stream while a walk is being launched
    a_no_ready_at_start: assert property (
        @(posedge clk) disable iff (reset) !(cmd_ready && walk_start)
    );

endmodule

`default_nettype wire

// ==== source/panel_cmd_pkg.sv ====
/* Command set of the LED panel processor: opcodes, the argument byte stream,
   the rectangle request and the frame-buffer write port */
`default_nettype none

package panel_cmd_pkg;

    typedef enum logic [7:0] {
        op_nop      = 8'h00,
        op_fillrect = 8'h01,
        op_clear    = 8'h02
    } cmd_opcode_e;

    // One accepted argument byte, from the dispatcher to the capture block
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
    } cmd_byte_t;

    // One spare bit on each coordinate so areas may reach past the panel edge
    typedef struct packed {
        logic [panel_geometry_pkg::column_bits:0]  x1;
        logic [panel_geometry_pkg::row_bits:0]     y1;
        logic [panel_geometry_pkg::column_bits:0]  width;
        logic [panel_geometry_pkg::row_bits:0]     height;
        logic [panel_geometry_pkg::color_bits-1:0] color;
    } fill_area_t;

    typedef struct packed {
        logic [panel_geometry_pkg::row_bits-1:0]          row;
        logic [panel_geometry_pkg::column_bits-1:0]       column;
        logic [panel_geometry_pkg::pixel_select_bits-1:0] pixel;
        logic [7:0]                                       data;
        logic                                             write_enable;
    } ram_write_t;

endpackage

`default_nettype wire

// ==== source/panel_geometry_pkg.sv ====
/* Panel geometry for the LED matrix command processor: panel size, pixel depth
   and the field widths derived from them */
`default_nettype none

package panel_geometry_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Panel size and pixel depth
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int unsigned pixel_width = 64;
    localparam int unsigned pixel_height = 32;
    localparam int unsigned bytes_per_pixel = 2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Derived widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int unsigned column_bits = $clog2(pixel_width);
    localparam int unsigned row_bits = $clog2(pixel_height);
    localparam int unsigned color_bits = bytes_per_pixel * 8;
    localparam int unsigned pixel_select_bits =
        bytes_per_pixel > 1 ? $clog2(bytes_per_pixel) : 1;

    // Stream bytes that carry one column value, x1 or width
    localparam int unsigned column_arg_bytes = (column_bits + 7) / 8;
    localparam int unsigned column_byte_count_bits =
        column_arg_bytes > 1 ? $clog2(column_arg_bytes) : 1;

endpackage

`default_nettype wire
